// ==== verilog/cpu_defs.svh ====
// processor width and depth constants

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////
// data path

// width of registers A, B, C and the IN/OUT bytes
`define CPU_DATA_W 8

////////////////////
// program store

// program counter width, wraps from 15 to 0
`define CPU_PC_W 4
`define CPU_MEM_DEPTH 16

// high nibble of every instruction word
`define CPU_OPCODE_W 4

`endif

// ==== verilog/cpu_isa_pkg.sv ====
// instruction set encodings

`include "cpu_defs.svh"

package cpu_isa_pkg;

  // opcodes 12 to 15 are not listed and execute as NOP
  typedef enum logic [`CPU_OPCODE_W-1:0] {
    NOP    = 4'd0,
    LDA_LO = 4'd1,
    LDA_HI = 4'd2,
    LDB_LO = 4'd3,
    LDB_HI = 4'd4,
    LDC_LO = 4'd5,
    LDC_HI = 4'd6,
    ADD    = 4'd7,
    SUB    = 4'd8,
    MUL    = 4'd9,
    OUT    = 4'd10,
    IN     = 4'd11
  } opcode_e;

  // register select for IN and OUT, REG_NONE turns them into NOP
  typedef enum logic [1:0] {
    REG_A    = 2'd0,
    REG_B    = 2'd1,
    REG_C    = 2'd2,
    REG_NONE = 2'd3
  } reg_sel_e;

  // one instruction byte, read as load-immediate or as register op
  typedef union packed {
    struct packed {
      opcode_e                               opcode;
      logic [`CPU_DATA_W-`CPU_OPCODE_W-1:0]  imm;
    } imm_view;
    struct packed {
      opcode_e                               opcode;
      logic [`CPU_DATA_W-`CPU_OPCODE_W-3:0]  rsvd;
      reg_sel_e                              sel;
    } reg_view;
  } instr_u;

endpackage

// ==== verilog/cpu_bus_pkg.sv ====
// program memory bus types

`include "cpu_defs.svh"

package cpu_bus_pkg;

  ////////////////////
  // shared by prog_mem, the arbiter and the fetch side

  // word address, same width as the program counter
  typedef logic [`CPU_PC_W-1:0] mem_addr_t;

  // one program word holds one instruction
  typedef logic [`CPU_DATA_W-1:0] mem_word_t;

endpackage

// ==== verilog/prog_mem.sv ====
// program memory
`timescale 1ns/10ps

`include "cpu_defs.svh"

module prog_mem (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  logic                   we,
  input  cpu_bus_pkg::mem_addr_t addr,
  input  cpu_bus_pkg::mem_word_t wdata,
  output cpu_bus_pkg::mem_word_t rdata
);

  cpu_bus_pkg::mem_word_t mem [`CPU_MEM_DEPTH];

  // single port, a read shows up on rdata one cycle after en
  always_ff @(posedge clk) begin
    if (rst) begin
      // all zero words decode as NOP
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

// ==== verilog/prog_mem_arbiter.sv ====
// program memory arbiter, host over fetch
`timescale 1ns/10ps

module prog_mem_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  // host write side
  input  logic                   host_req,
  input  cpu_bus_pkg::mem_addr_t host_addr,
  input  cpu_bus_pkg::mem_word_t host_data,
  output logic                   host_ack,
  // fetch side
  input  logic                   fetch_req,
  input  cpu_bus_pkg::mem_addr_t fetch_addr,
  output logic                   fetch_ack,
  output cpu_bus_pkg::mem_word_t fetch_data,
  // memory port
  input  cpu_bus_pkg::mem_word_t mem_rdata,
  output logic                   mem_en,
  output logic                   mem_we,
  output cpu_bus_pkg::mem_addr_t mem_addr,
  output cpu_bus_pkg::mem_word_t mem_wdata
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ACCESS = 2'd1;
  localparam logic [1:0] ST_ACK    = 2'd2;

  logic [1:0] state;
  logic       owner_host;
  logic       grant_host;
  logic       grant_fetch;

  ////////////////////
  // grant

  // host wins a tie
  assign grant_host  = (state == ST_IDLE) && host_req;
  assign grant_fetch = (state == ST_IDLE) && !host_req && fetch_req;

  // the memory works on the grant edge
  assign mem_en    = grant_host || grant_fetch;
  assign mem_we    = grant_host;
  assign mem_addr  = grant_host ? host_addr : fetch_addr;
  assign mem_wdata = host_data;

  ////////////////////
  // handshake sequencing

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      owner_host <= 1'b0;
      host_ack   <= 1'b0;
      fetch_ack  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (mem_en) begin
            owner_host <= grant_host;
            state      <= ST_ACCESS;
          end
        end
        // read word is on mem_rdata now
        ST_ACCESS: begin
          host_ack  <= owner_host;
          fetch_ack <= !owner_host;
          state     <= ST_ACK;
        end
        // hold ack until the owner drops its req
        ST_ACK: begin
          if (owner_host && !host_req) begin
            host_ack <= 1'b0;
            state    <= ST_IDLE;
          end else if (!owner_host && !fetch_req) begin
            fetch_ack <= 1'b0;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // fetch word stays valid while fetch_ack is high
  always_ff @(posedge clk) begin
    if (state == ST_ACCESS && !owner_host) begin
      fetch_data <= mem_rdata;
    end
  end

endmodule

// ==== verilog/datapath.sv ====
// register file and ALU
`timescale 1ns/10ps

`include "cpu_defs.svh"

module datapath (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   exec_stb,
  input  cpu_isa_pkg::instr_u    instr,
  input  logic                   in_stb,
  input  logic [`CPU_DATA_W-1:0] in_byte,
  output logic [`CPU_DATA_W-1:0] sel_data
);

  // immediate nibble width, also the low half of a register
  localparam int NIB_W = `CPU_DATA_W - `CPU_OPCODE_W;

  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_b;
  logic [`CPU_DATA_W-1:0] reg_c;

  ////////////////////
  // register writes

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else if (exec_stb) begin
      case (instr.imm_view.opcode)
        cpu_isa_pkg::LDA_LO: reg_a[NIB_W-1:0]           <= instr.imm_view.imm;
        cpu_isa_pkg::LDA_HI: reg_a[`CPU_DATA_W-1:NIB_W] <= instr.imm_view.imm;
        cpu_isa_pkg::LDB_LO: reg_b[NIB_W-1:0]           <= instr.imm_view.imm;
        cpu_isa_pkg::LDB_HI: reg_b[`CPU_DATA_W-1:NIB_W] <= instr.imm_view.imm;
        cpu_isa_pkg::LDC_LO: reg_c[NIB_W-1:0]           <= instr.imm_view.imm;
        cpu_isa_pkg::LDC_HI: reg_c[`CPU_DATA_W-1:NIB_W] <= instr.imm_view.imm;
        // all three wrap modulo 256
        cpu_isa_pkg::ADD:    reg_c <= reg_a + reg_b;
        cpu_isa_pkg::SUB:    reg_c <= reg_a - reg_b;
        // low byte of the product
        cpu_isa_pkg::MUL:    reg_c <= reg_a * reg_b;
        // NOP, IN, OUT and the spare codes write nothing here
        default: ;
      endcase
    end else if (in_stb) begin
      case (instr.reg_view.sel)
        cpu_isa_pkg::REG_A: reg_a <= in_byte;
        cpu_isa_pkg::REG_B: reg_b <= in_byte;
        cpu_isa_pkg::REG_C: reg_c <= in_byte;
        default: ;
      endcase
    end
  end

  ////////////////////
  // register read for OUT

  always_comb begin
    case (instr.reg_view.sel)
      cpu_isa_pkg::REG_A: sel_data = reg_a;
      cpu_isa_pkg::REG_B: sel_data = reg_b;
      cpu_isa_pkg::REG_C: sel_data = reg_c;
      default:            sel_data = '0;
    endcase
  end

endmodule

// ==== verilog/control_unit.sv ====
// fetch and execute sequencer
`timescale 1ns/10ps

`include "cpu_defs.svh"

module control_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  // fetch port
  input  logic                   fetch_ack,
  input  cpu_bus_pkg::mem_word_t fetch_data,
  output logic                   fetch_req,
  output cpu_bus_pkg::mem_addr_t fetch_addr,
  // datapath side
  input  logic [`CPU_DATA_W-1:0] sel_data,
  output logic                   exec_stb,
  output cpu_isa_pkg::instr_u    instr,
  output logic                   in_stb,
  output logic [`CPU_DATA_W-1:0] in_byte,
  // IN port
  input  logic [`CPU_DATA_W-1:0] in_data,
  input  logic                   in_ack,
  output logic                   in_req,
  // OUT port
  input  logic                   out_ack,
  output logic                   out_req,
  output logic [`CPU_DATA_W-1:0] out_data
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_FETCH    = 3'd1;
  localparam logic [2:0] ST_EXEC     = 3'd2;
  localparam logic [2:0] ST_IN_WAIT  = 3'd3;
  localparam logic [2:0] ST_IN_REL   = 3'd4;
  localparam logic [2:0] ST_OUT_WAIT = 3'd5;
  localparam logic [2:0] ST_OUT_REL  = 3'd6;

  logic [2:0]             state;
  cpu_bus_pkg::mem_addr_t pc;
  logic                   sel_valid;
  logic                   is_in;
  logic                   is_out;

  ////////////////////
  // decode

  // only IN and OUT matter here, register writes live in the datapath
  assign sel_valid = instr.reg_view.sel != cpu_isa_pkg::REG_NONE;
  assign is_in     = (instr.reg_view.opcode == cpu_isa_pkg::IN) && sel_valid;
  assign is_out    = (instr.reg_view.opcode == cpu_isa_pkg::OUT) && sel_valid;

  // pc holds still for the whole fetch
  assign fetch_addr = pc;

  ////////////////////
  // sequencer

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      pc        <= '0;
      instr     <= '0;
      fetch_req <= 1'b0;
      exec_stb  <= 1'b0;
      in_stb    <= 1'b0;
      in_req    <= 1'b0;
      out_req   <= 1'b0;
    end else begin
      // strobes last one cycle
      exec_stb <= 1'b0;
      in_stb   <= 1'b0;
      case (state)
        // a low run stops here, after the last handshake
        ST_IDLE: begin
          if (run && !fetch_ack) begin
            fetch_req <= 1'b1;
            state     <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (fetch_ack) begin
            instr     <= fetch_data;
            fetch_req <= 1'b0;
            exec_stb  <= 1'b1;
            pc        <= pc + 1'b1;
            state     <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (is_in) begin
            in_req <= 1'b1;
            state  <= ST_IN_WAIT;
          end else if (is_out) begin
            out_req <= 1'b1;
            state   <= ST_OUT_WAIT;
          end else begin
            state <= ST_IDLE;
          end
        end
        ST_IN_WAIT: begin
          if (in_ack) begin
            in_stb <= 1'b1;
            in_req <= 1'b0;
            state  <= ST_IN_REL;
          end
        end
        ST_IN_REL: begin
          if (!in_ack) begin
            state <= ST_IDLE;
          end
        end
        ST_OUT_WAIT: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= ST_OUT_REL;
          end
        end
        ST_OUT_REL: begin
          if (!out_ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // byte captures for the two ports
  always_ff @(posedge clk) begin
    if (state == ST_EXEC && is_out) begin
      out_data <= sel_data;
    end
    if (state == ST_IN_WAIT && in_ack) begin
      in_byte <= in_data;
    end
  end

endmodule

// ==== verilog/cpu_top.sv ====
// 8-bit accumulator processor top
`timescale 1ns/10ps

`include "cpu_defs.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  // host program load
  input  logic                   host_req,
  input  cpu_bus_pkg::mem_addr_t host_addr,
  input  cpu_bus_pkg::mem_word_t host_data,
  output logic                   host_ack,
  // IN port
  input  logic [`CPU_DATA_W-1:0] in_data,
  input  logic                   in_ack,
  output logic                   in_req,
  // OUT port
  input  logic                   out_ack,
  output logic                   out_req,
  output logic [`CPU_DATA_W-1:0] out_data
);

  logic                   fetch_req;
  logic                   fetch_ack;
  cpu_bus_pkg::mem_addr_t fetch_addr;
  cpu_bus_pkg::mem_word_t fetch_data;
  logic                   mem_en;
  logic                   mem_we;
  cpu_bus_pkg::mem_addr_t mem_addr;
  cpu_bus_pkg::mem_word_t mem_wdata;
  cpu_bus_pkg::mem_word_t mem_rdata;
  logic                   exec_stb;
  cpu_isa_pkg::instr_u    instr;
  logic                   in_stb;
  logic [`CPU_DATA_W-1:0] in_byte;
  logic [`CPU_DATA_W-1:0] sel_data;

  prog_mem u_prog_mem (
    .clk   (clk),
    .rst   (rst),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  prog_mem_arbiter u_prog_mem_arbiter (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_addr  (host_addr),
    .host_data  (host_data),
    .host_ack   (host_ack),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .mem_rdata  (mem_rdata),
    .mem_en     (mem_en),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
  );

  control_unit u_control_unit (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .sel_data   (sel_data),
    .exec_stb   (exec_stb),
    .instr      (instr),
    .in_stb     (in_stb),
    .in_byte    (in_byte),
    .in_data    (in_data),
    .in_ack     (in_ack),
    .in_req     (in_req),
    .out_ack    (out_ack),
    .out_req    (out_req),
    .out_data   (out_data)
  );

  datapath u_datapath (
    .clk      (clk),
    .rst      (rst),
    .exec_stb (exec_stb),
    .instr    (instr),
    .in_stb   (in_stb),
    .in_byte  (in_byte),
    .sel_data (sel_data)
  );

endmodule

// ==== test/cpu_tb.sv ====
// processor testbench
`timescale 1ns/10ps

`include "cpu_defs.svh"

module cpu_tb;

  localparam int TIMEOUT_CYCLES = 20000;

  logic                   clk;
  logic                   rst;
  logic                   run;
  logic                   host_req;
  logic [`CPU_PC_W-1:0]   host_addr;
  logic [`CPU_DATA_W-1:0] host_data;
  logic                   host_ack;
  logic [`CPU_DATA_W-1:0] in_data;
  logic                   in_ack;
  logic                   in_req;
  logic                   out_ack;
  logic                   out_req;
  logic [`CPU_DATA_W-1:0] out_data;

  // stimulus and reference model state
  logic [`CPU_DATA_W-1:0] prog [`CPU_MEM_DEPTH];
  logic [`CPU_DATA_W-1:0] model_mem [`CPU_MEM_DEPTH];
  logic [`CPU_DATA_W-1:0] m_a;
  logic [`CPU_DATA_W-1:0] m_b;
  logic [`CPU_DATA_W-1:0] m_c;
  int                     m_pc;
  logic [`CPU_DATA_W-1:0] in_bytes [$];
  logic [`CPU_DATA_W-1:0] out_log [$];
  int                     out_count;
  int                     cycle_count;
  int                     error_count;
  logic                   halted;

  cpu_top u_cpu_top (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .host_req  (host_req),
    .host_addr (host_addr),
    .host_data (host_data),
    .host_ack  (host_ack),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .in_req    (in_req),
    .out_ack   (out_ack),
    .out_req   (out_req),
    .out_data  (out_data)
  );

  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    error_count++;
    $display("Error: time %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_now("timeout, the run did not finish within the cycle limit");
    end
  end

  ////////////////////
  // protocol checks

  quiet_when_halted: assert property (@(posedge clk) disable iff (rst)
    halted |-> (!out_req && !in_req))
    else fail_now("in_req or out_req high while the CPU should be stopped");
  host_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(host_ack) |-> host_req)
    else fail_now("host_ack rose without host_req");
  host_ack_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(host_ack) |-> !$past(host_req))
    else fail_now("host_ack fell before host_req fell");
  out_data_stable: assert property (@(posedge clk) disable iff (rst)
    (out_req && $past(out_req)) |-> (out_data == $past(out_data)))
    else fail_now("out_data changed while out_req was high");
  out_req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(out_req) |-> !out_ack)
    else fail_now("out_req rose while out_ack was still high");
  in_req_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(in_req) |-> $past(in_ack))
    else fail_now("in_req fell before in_ack rose");
  in_req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(in_req) |-> !in_ack)
    else fail_now("in_req rose again before in_ack fell");

  ////////////////////
  // reference model

  function automatic logic [`CPU_DATA_W-1:0] model_reg(input logic [1:0] sel);
    case (sel)
      2'd0:    return m_a;
      2'd1:    return m_b;
      2'd2:    return m_c;
      default: return '0;
    endcase
  endfunction

  // steps the program until the next OUT of a real register
  task automatic model_next_out(output logic [`CPU_DATA_W-1:0] val);
    logic [`CPU_DATA_W-1:0] w;
    logic [3:0]             imm;
    logic [1:0]             sel;
    int                     steps;
    logic                   found;
    found = 1'b0;
    steps = 0;
    val   = '0;
    while (!found && steps < 2 * `CPU_MEM_DEPTH) begin
      w     = model_mem[m_pc];
      imm   = w[3:0];
      sel   = w[1:0];
      m_pc  = (m_pc + 1) % `CPU_MEM_DEPTH;
      steps = steps + 1;
      case (w[7:4])
        cpu_isa_pkg::LDA_LO: m_a[3:0] = imm;
        cpu_isa_pkg::LDA_HI: m_a[7:4] = imm;
        cpu_isa_pkg::LDB_LO: m_b[3:0] = imm;
        cpu_isa_pkg::LDB_HI: m_b[7:4] = imm;
        cpu_isa_pkg::LDC_LO: m_c[3:0] = imm;
        cpu_isa_pkg::LDC_HI: m_c[7:4] = imm;
        cpu_isa_pkg::ADD:    m_c = m_a + m_b;
        cpu_isa_pkg::SUB:    m_c = m_a - m_b;
        cpu_isa_pkg::MUL:    m_c = m_a * m_b;
        cpu_isa_pkg::OUT: begin
          if (sel != 2'd3) begin
            val   = model_reg(sel);
            found = 1'b1;
          end
        end
        cpu_isa_pkg::IN: begin
          if (sel != 2'd3) begin
            if (in_bytes.size() == 0) begin
              fail_now("model reached an IN that the CPU never requested");
            end
            case (sel)
              2'd0:    m_a = in_bytes.pop_front();
              2'd1:    m_b = in_bytes.pop_front();
              default: m_c = in_bytes.pop_front();
            endcase
          end
        end
        default: ;
      endcase
    end
    if (!found) begin
      fail_now("CPU produced an OUT where the program has none");
    end
  endtask

  ////////////////////
  // environment

  task automatic in_source();
    logic [`CPU_DATA_W-1:0] value;
    int                     d;
    forever begin
      @(posedge clk);
      if (in_req && !in_ack) begin
        value = $urandom % 256;
        in_bytes.push_back(value);
        d = $urandom % 4;
        repeat (d) @(posedge clk);
        in_data <= value;
        in_ack  <= 1'b1;
        do @(posedge clk); while (in_req);
        // ack may linger well past the req drop
        d = $urandom % 16;
        repeat (d) @(posedge clk);
        in_ack <= 1'b0;
      end
    end
  endtask

  task automatic out_sink();
    logic [`CPU_DATA_W-1:0] expected;
    int                     d;
    forever begin
      @(posedge clk);
      if (out_req && !out_ack) begin
        model_next_out(expected);
        assert (out_data == expected)
          else fail_now($sformatf("OUT byte %0d is %02h, expected %02h",
                                  out_count, out_data, expected));
        out_log.push_back(out_data);
        out_count++;
        d = $urandom % 4;
        repeat (d) @(posedge clk);
        out_ack <= 1'b1;
        do @(posedge clk); while (out_req);
        // ack may linger well past the req drop
        d = $urandom % 16;
        repeat (d) @(posedge clk);
        out_ack <= 1'b0;
      end
    end
  endtask

  task automatic host_write(input int addr, input logic [`CPU_DATA_W-1:0] data);
    @(posedge clk);
    host_req  <= 1'b1;
    host_addr <= addr[`CPU_PC_W-1:0];
    host_data <= data;
    do @(posedge clk); while (!host_ack);
    host_req <= 1'b0;
    do @(posedge clk); while (host_ack);
  endtask

  task automatic load_program();
    for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
      host_write(i, prog[i]);
      model_mem[i] = prog[i];
    end
  endtask

  // run until n more OUT bytes, then drop run and watch for stray activity
  task automatic run_outs(input int n);
    int target;
    int stop_count;
    target = out_count + n;
    @(posedge clk);
    halted <= 1'b0;
    run    <= 1'b1;
    while (out_count < target) @(posedge clk);
    run <= 1'b0;
    stop_count = out_count;
    repeat (40) @(posedge clk);
    assert (out_count == stop_count && !out_req && !in_req)
      else fail_now("CPU kept going after run was dropped");
    halted <= 1'b1;
  endtask

  function automatic logic [7:0] imm_word(input logic [3:0] op, input logic [3:0] nib);
    return {op, nib};
  endfunction

  function automatic logic [7:0] reg_word(input logic [3:0] op, input logic [1:0] sel);
    return {op, 2'b00, sel};
  endfunction

  function automatic logic [3:0] rand_nib();
    return $urandom % 16;
  endfunction

  task automatic clear_prog();
    for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
      prog[i] = '0;
    end
  endtask

  ////////////////////
  // test sequence

  initial begin
    void'($urandom(2281));
    clk = 1'b0;
    rst = 1'b1;
    run = 1'b0;
    host_req = 1'b0;
    host_addr = '0;
    host_data = '0;
    in_data = '0;
    in_ack = 1'b0;
    out_ack = 1'b0;
    halted = 1'b1;
    m_pc = 0;
    m_a = '0;
    m_b = '0;
    m_c = '0;
    out_count = 0;
    cycle_count = 0;
    error_count = 0;
    fork
      in_source();
      out_sink();
    join_none
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (5) @(posedge clk);

    // load immediates, last OUT at word 15 so a stop leaves pc at 0
    clear_prog();
    prog[0]  = imm_word(cpu_isa_pkg::LDA_LO, rand_nib());
    prog[1]  = imm_word(cpu_isa_pkg::LDA_HI, rand_nib());
    prog[2]  = imm_word(cpu_isa_pkg::LDB_LO, rand_nib());
    prog[3]  = imm_word(cpu_isa_pkg::LDB_HI, rand_nib());
    prog[4]  = imm_word(cpu_isa_pkg::LDC_LO, rand_nib());
    prog[5]  = imm_word(cpu_isa_pkg::LDC_HI, rand_nib());
    prog[6]  = reg_word(cpu_isa_pkg::OUT, 2'd0);
    prog[7]  = reg_word(cpu_isa_pkg::OUT, 2'd1);
    prog[15] = reg_word(cpu_isa_pkg::OUT, 2'd2);
    load_program();
    run_outs(6);

    // ALU
    clear_prog();
    prog[0]  = imm_word(cpu_isa_pkg::LDA_LO, rand_nib());
    prog[1]  = imm_word(cpu_isa_pkg::LDA_HI, rand_nib());
    prog[2]  = imm_word(cpu_isa_pkg::LDB_LO, rand_nib());
    prog[3]  = imm_word(cpu_isa_pkg::LDB_HI, rand_nib());
    prog[4]  = imm_word(cpu_isa_pkg::ADD, 4'd0);
    prog[5]  = reg_word(cpu_isa_pkg::OUT, 2'd2);
    prog[6]  = imm_word(cpu_isa_pkg::SUB, 4'd0);
    prog[7]  = reg_word(cpu_isa_pkg::OUT, 2'd2);
    prog[8]  = imm_word(cpu_isa_pkg::MUL, 4'd0);
    prog[9]  = reg_word(cpu_isa_pkg::OUT, 2'd2);
    prog[15] = reg_word(cpu_isa_pkg::OUT, 2'd1);
    load_program();
    run_outs(8);

    // IN to each register, plus IN and OUT of the none select
    // back to back INs so a new in_req can meet a lingering in_ack
    clear_prog();
    prog[0]  = reg_word(cpu_isa_pkg::IN, 2'd0);
    prog[1]  = reg_word(cpu_isa_pkg::IN, 2'd1);
    prog[2]  = reg_word(cpu_isa_pkg::IN, 2'd2);
    prog[3]  = reg_word(cpu_isa_pkg::OUT, 2'd0);
    prog[4]  = reg_word(cpu_isa_pkg::OUT, 2'd1);
    prog[5]  = reg_word(cpu_isa_pkg::IN, 2'd3);
    prog[6]  = reg_word(cpu_isa_pkg::OUT, 2'd3);
    prog[15] = reg_word(cpu_isa_pkg::OUT, 2'd2);
    load_program();
    run_outs(6);

    // short program, three passes through the wrap
    clear_prog();
    prog[0] = imm_word(cpu_isa_pkg::LDA_LO, rand_nib());
    prog[1] = imm_word(cpu_isa_pkg::LDA_HI, rand_nib());
    prog[2] = reg_word(cpu_isa_pkg::OUT, 2'd0);
    prog[3] = imm_word(cpu_isa_pkg::LDB_LO, rand_nib());
    prog[4] = reg_word(cpu_isa_pkg::OUT, 2'd1);
    load_program();
    run_outs(6);

    // reload while stopped, pc resumes at 5 in the new program
    for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
      if (i % 2 == 0) begin
        prog[i] = imm_word(cpu_isa_pkg::LDC_LO, rand_nib());
      end else begin
        prog[i] = reg_word(cpu_isa_pkg::OUT, 2'd2);
      end
    end
    load_program();
    run_outs(8);

    if (error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/prog_mem.sv
verilog/prog_mem_arbiter.sv
verilog/datapath.sv
verilog/control_unit.sv
verilog/cpu_top.sv
test/cpu_tb.sv
